/* design/frame_sync.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nr_settings.svh"

module frame_sync (
    input  wire logic              clk_i,
    input  wire logic              reset_ni,
    input  wire logic [`NR_DW-1:0] s_tdata_i,
    input  wire logic              s_tvalid_i,
    ssb_event_if.sink              ev,
    sync_cfg_if.sync               cfg,
    output logic      [`NR_DW-1:0] m_tdata_o,
    output logic                   m_tvalid_o,
    output nr_frame_pkg::cp_len_t  cp_len_o,
    output logic                   symbol_start_o,
    output logic                   pbch_start_o,
    output logic                   sss_start_o
);
    import nr_frame_pkg::*;
    import nr_cfg_pkg::*;

    // search window closes this many samples after the boundary
    localparam sc_cnt_t LOST_SC = 6'd3;

    lock_state_e state;
    sc_cnt_t     sc_cnt;
    sym_idx_t    sym_idx;
    ssb_period_t syms_since_ssb;
    logic        find_ssb;
    logic        lost_q;
    logic        fsm_clr;
    sym_idx_t    sym_cur;
    cp_len_t     cp_cur;
    sc_cnt_t     sc_last;
    logic        period_end;

    assign fsm_clr = !reset_ni || !cfg.enable;

    // ibar correction applies in the cycle it arrives
    assign sym_cur = (state == WAIT_IBAR && ev.ibar_valid)
                   ? sym_wrap({1'b0, sym_idx} + {1'b0, IBAR_SYM_OFS[ev.ibar[1:0]]})
                   : sym_idx;

    assign cp_cur     = cp_for_sym(sym_cur);
    assign sc_last    = sc_cnt_t'(`NR_FFT_LEN - 1) + sc_cnt_t'(cp_cur);
    assign period_end = (syms_since_ssb == cfg.ssb_period - 1'b1);

    always_ff @(posedge clk_i) begin
        m_tdata_o <= s_tdata_i;
        if (!reset_ni) begin
            m_tvalid_o <= 1'b0;
        end else begin
            m_tvalid_o <= s_tvalid_i;
        end
    end

    // sc_cnt is the index of the current input sample within its symbol
    always_ff @(posedge clk_i) begin
        if (fsm_clr) begin
            state          <= WAIT_SSB;
            sc_cnt         <= '0;
            sym_idx        <= '0;
            syms_since_ssb <= '0;
            find_ssb       <= 1'b0;
            lost_q         <= 1'b0;
            cp_len_o       <= cp_len_t'(`NR_CP2_LEN);
            symbol_start_o <= 1'b0;
            pbch_start_o   <= 1'b0;
            sss_start_o    <= 1'b0;
        end else begin
            symbol_start_o <= 1'b0;
            pbch_start_o   <= 1'b0;
            sss_start_o    <= 1'b0;
            lost_q         <= 1'b0;

            if (state == WAIT_SSB) begin
                // detection sample opens the SSB symbol
                if (ev.nid2_valid) begin
                    state          <= WAIT_IBAR;
                    sc_cnt         <= sc_cnt_t'(1);
                    sym_idx        <= sym_idx_t'(`NR_SSB_SYM0);
                    syms_since_ssb <= '0;
                    cp_len_o       <= cp_for_sym(sym_idx_t'(`NR_SSB_SYM0));
                    symbol_start_o <= 1'b1;
                    pbch_start_o   <= 1'b1;
                end
            end else begin
                if (state == WAIT_IBAR && ev.ibar_valid) begin
                    state <= SYNCED;
                end
                sym_idx <= sym_cur;

                if (s_tvalid_i) begin
                    if (sc_cnt == '0) begin
                        symbol_start_o <= 1'b1;
                        cp_len_o       <= cp_cur;
                        // SSS sits two symbols after the PSS
                        sss_start_o    <= (syms_since_ssb == ssb_period_t'(2));
                    end
                    if (sc_cnt == sc_last) begin
                        sc_cnt         <= '0;
                        sym_idx        <= sym_wrap({1'b0, sym_cur} + 6'd1);
                        syms_since_ssb <= period_end ? '0 : syms_since_ssb + 1'b1;
                    end else begin
                        sc_cnt <= sc_cnt + 1'b1;
                    end
                    if (state == SYNCED && period_end && sc_cnt == sc_last - 1'b1) begin
                        find_ssb <= 1'b1;
                    end
                end

                if (find_ssb && s_tvalid_i) begin
                    if (ev.nid2_valid) begin
                        pbch_start_o <= 1'b1;
                        find_ssb     <= 1'b0;
                    end else if (sc_cnt == LOST_SC) begin
                        // no SSB near the boundary, start over
                        state    <= WAIT_SSB;
                        find_ssb <= 1'b0;
                        lost_q   <= 1'b1;
                    end
                end
            end
        end
    end

    assign cfg.lock_state = state;
    assign cfg.sym_idx    = sym_idx;
    assign cfg.lost_pulse = lost_q;

    // decoder only reports ibar for an SSB that was detected
    a_ibar_after_ssb: assert property (@(posedge clk_i) disable iff (fsm_clr)
        ev.ibar_valid |-> state != WAIT_SSB);

    a_start_on_sample: assert property (@(posedge clk_i) disable iff (fsm_clr)
        (state == SYNCED) && (symbol_start_o || pbch_start_o) |-> $past(s_tvalid_i));

endmodule

`default_nettype wire

/* design/nr_cfg_pkg.sv */
`default_nettype none

`include "nr_settings.svh"

package nr_cfg_pkg;

    typedef enum logic [`NR_APB_AW-1:0] {
        CTRL       = 'h00,
        SSB_PERIOD = 'h04,
        WINDOW     = 'h08,
        STATUS     = 'h0C,
        LOST_CNT   = 'h10
    } reg_addr_e;

    // SSB period in symbols
    typedef logic [15:0] ssb_period_t;
    // early and late margins in samples
    typedef logic [11:0] window_t;
    // late margin sits in the upper half of WINDOW
    localparam int WIN_LATE_LSB = 16;

    // wide enough for a full SSB period in samples
    typedef logic [23:0] smp_cnt_t;

    typedef struct packed {
        logic [`NR_APB_DW-10:0]    rsvd;
        nr_frame_pkg::pss_mode_e   mode;
        nr_frame_pkg::sym_idx_t    sym;
        nr_frame_pkg::lock_state_e lock;
    } status_t;

    // every run of seven symbols holds exactly one long CP
    function automatic smp_cnt_t ssb_period_samples(ssb_period_t period);
        smp_cnt_t base;
        smp_cnt_t extra;
        base  = smp_cnt_t'(period) * smp_cnt_t'(`NR_FFT_LEN + `NR_CP2_LEN);
        extra = smp_cnt_t'(period / (`NR_SYM_PER_SF / 2)) * smp_cnt_t'(`NR_CP1_LEN - `NR_CP2_LEN);
        return base + extra;
    endfunction

endpackage

`default_nettype wire

/* design/nr_frame_pkg.sv */
`default_nettype none

`include "nr_settings.svh"

package nr_frame_pkg;

    typedef logic [4:0] sym_idx_t;
    typedef logic [4:0] cp_len_t;
    typedef logic [5:0] sc_cnt_t;
    typedef logic [2:0] ibar_t;
    typedef logic [1:0] nid2_t;

    typedef enum logic [1:0] {
        WAIT_SSB,
        WAIT_IBAR,
        SYNCED
    } lock_state_e;

    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        FIND   = 2'd1,
        PAUSE  = 2'd2
    } pss_mode_e;

    // SSB symbol offset within the subframe pair, indexed by ibar
    localparam sym_idx_t IBAR_SYM_OFS [4] = '{5'd0, 5'd6, 5'd14, 5'd20};

    // symbols 0 and 7 carry the long prefix
    function automatic cp_len_t cp_for_sym(sym_idx_t sym);
        if (sym == 5'd0 || sym == 5'd7) begin
            return cp_len_t'(`NR_CP1_LEN);
        end
        return cp_len_t'(`NR_CP2_LEN);
    endfunction

    // modulo symbols per subframe, input below three subframes
    function automatic sym_idx_t sym_wrap(logic [5:0] sym);
        logic [5:0] r;
        r = sym;
        if (r >= 6'(2 * `NR_SYM_PER_SF)) begin
            r = r - 6'(2 * `NR_SYM_PER_SF);
        end else if (r >= 6'(`NR_SYM_PER_SF)) begin
            r = r - 6'(`NR_SYM_PER_SF);
        end
        return sym_idx_t'(r);
    endfunction

endpackage

`default_nettype wire

/* design/nr_sync_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nr_settings.svh"

module nr_sync_top (
    input  wire logic                    clk_i,
    input  wire logic                    reset_ni,
    input  wire logic                    psel_i,
    input  wire logic                    penable_i,
    input  wire logic                    pwrite_i,
    input  wire logic [`NR_APB_AW-1:0]   paddr_i,
    input  wire logic [`NR_APB_DW-1:0]   pwdata_i,
    output logic      [`NR_APB_DW-1:0]   prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    input  wire logic [`NR_DW-1:0]       s_tdata_i,
    input  wire logic                    s_tvalid_i,
    input  wire nr_frame_pkg::nid2_t     nid2_i,
    input  wire logic                    nid2_valid_i,
    input  wire nr_frame_pkg::ibar_t     ibar_i,
    input  wire logic                    ibar_valid_i,
    output nr_frame_pkg::pss_mode_e      pss_mode_o,
    output logic      [`NR_DW-1:0]       m_tdata_o,
    output logic                         m_tvalid_o,
    output nr_frame_pkg::cp_len_t        cp_len_o,
    output logic                         symbol_start_o,
    output logic                         pbch_start_o,
    output logic                         sss_start_o
);
    ssb_event_if ssb_ev ();
    sync_cfg_if  sync_cfg ();

    assign ssb_ev.nid2       = nid2_i;
    assign ssb_ev.nid2_valid = nid2_valid_i;
    assign ssb_ev.ibar       = ibar_i;
    assign ssb_ev.ibar_valid = ibar_valid_i;

    sync_regs u_sync_regs (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (nr_cfg_pkg::reg_addr_e'(paddr_i)),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .cfg       (sync_cfg)
    );

    pss_window_ctrl u_pss_window_ctrl (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .ev         (ssb_ev),
        .cfg        (sync_cfg),
        .pss_mode_o (pss_mode_o)
    );

    frame_sync u_frame_sync (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .s_tdata_i      (s_tdata_i),
        .s_tvalid_i     (s_tvalid_i),
        .ev             (ssb_ev),
        .cfg            (sync_cfg),
        .m_tdata_o      (m_tdata_o),
        .m_tvalid_o     (m_tvalid_o),
        .cp_len_o       (cp_len_o),
        .symbol_start_o (symbol_start_o),
        .pbch_start_o   (pbch_start_o),
        .sss_start_o    (sss_start_o)
    );

endmodule

`default_nettype wire

/* design/pss_window_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module pss_window_ctrl (
    input  wire logic               clk_i,
    input  wire logic               reset_ni,
    ssb_event_if.sink               ev,
    sync_cfg_if.pss                 cfg,
    output nr_frame_pkg::pss_mode_e pss_mode_o
);
    import nr_frame_pkg::*;
    import nr_cfg_pkg::*;

    pss_mode_e mode_q;
    smp_cnt_t  smp_cnt;
    smp_cnt_t  period_smp;
    smp_cnt_t  wake_at;
    smp_cnt_t  give_up_at;

    assign period_smp = ssb_period_samples(cfg.ssb_period);
    // detector wakes early_win ahead of the expected SSB and gives up late_win after
    assign wake_at    = period_smp - smp_cnt_t'(cfg.early_win);
    assign give_up_at = period_smp + smp_cnt_t'(cfg.late_win);

    // smp_cnt holds the samples since the last SSB, one per cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni || !cfg.enable) begin
            mode_q  <= SEARCH;
            smp_cnt <= '0;
        end else begin
            case (mode_q)
                SEARCH: begin
                    if (ev.nid2_valid) begin
                        mode_q  <= PAUSE;
                        smp_cnt <= smp_cnt_t'(1);
                    end
                end
                PAUSE: begin
                    smp_cnt <= smp_cnt + 1'b1;
                    if (smp_cnt >= wake_at) begin
                        mode_q <= FIND;
                    end
                end
                FIND: begin
                    if (ev.nid2_valid) begin
                        mode_q  <= PAUSE;
                        smp_cnt <= smp_cnt_t'(1);
                    end else if (smp_cnt > give_up_at) begin
                        mode_q  <= SEARCH;
                        smp_cnt <= '0;
                    end else begin
                        smp_cnt <= smp_cnt + 1'b1;
                    end
                end
                default: mode_q <= SEARCH;
            endcase
        end
    end

    assign pss_mode_o   = mode_q;
    assign cfg.pss_mode = mode_q;

    a_mode_legal: assert property (@(posedge clk_i) disable iff (!reset_ni)
        pss_mode_o inside {SEARCH, FIND, PAUSE});

endmodule

`default_nettype wire

/* design/ssb_event_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface ssb_event_if;
    import nr_frame_pkg::*;

    // sector identity from the PSS detector
    nid2_t nid2;
    logic  nid2_valid;

    // SSB index from the PBCH decoder, arrives some symbols later
    ibar_t ibar;
    logic  ibar_valid;

    modport source (
        output nid2, nid2_valid, ibar, ibar_valid
    );

    modport sink (
        input nid2, nid2_valid, ibar, ibar_valid
    );
endinterface

`default_nettype wire

/* design/sync_cfg_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface sync_cfg_if;
    import nr_frame_pkg::*;
    import nr_cfg_pkg::*;

    // configuration, held until software rewrites it
    logic        enable;
    ssb_period_t ssb_period;
    window_t     early_win;
    window_t     late_win;

    // status back to the register block
    lock_state_e lock_state;
    sym_idx_t    sym_idx;
    logic        lost_pulse;
    pss_mode_e   pss_mode;

    modport regs (
        output enable, ssb_period, early_win, late_win,
        input  lock_state, sym_idx, lost_pulse, pss_mode
    );

    modport sync (
        input  enable, ssb_period,
        output lock_state, sym_idx, lost_pulse
    );

    modport pss (
        input  enable, ssb_period, early_win, late_win,
        output pss_mode
    );
endinterface

`default_nettype wire

/* design/sync_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nr_settings.svh"

module sync_regs (
    input  wire logic                   clk_i,
    input  wire logic                   reset_ni,
    input  wire logic                   psel_i,
    input  wire logic                   penable_i,
    input  wire logic                   pwrite_i,
    input  wire nr_cfg_pkg::reg_addr_e  paddr_i,
    input  wire logic [`NR_APB_DW-1:0]  pwdata_i,
    output logic      [`NR_APB_DW-1:0]  prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    sync_cfg_if.regs                    cfg
);
    import nr_cfg_pkg::*;

    // two subframes between SSBs, eight samples either side
    localparam ssb_period_t PERIOD_RST = 16'd28;
    localparam window_t     WIN_RST    = 12'd8;

    logic                  access;
    logic                  acc_err;
    status_t               status;
    logic [`NR_APB_DW-1:0] lost_cnt;

    assign access   = psel_i && penable_i;
    assign pready_o = 1'b1;

    // STATUS and LOST_CNT are read only
    always_comb begin
        case (paddr_i)
            CTRL, SSB_PERIOD, WINDOW: acc_err = 1'b0;
            STATUS, LOST_CNT:         acc_err = pwrite_i;
            default:                  acc_err = 1'b1;
        endcase
    end

    assign pslverr_o = access && acc_err;

    assign status = '{
        rsvd: '0,
        mode: cfg.pss_mode,
        sym:  cfg.sym_idx,
        lock: cfg.lock_state
    };

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            CTRL:       prdata_o[0] = cfg.enable;
            SSB_PERIOD: prdata_o[$bits(ssb_period_t)-1:0] = cfg.ssb_period;
            WINDOW: begin
                prdata_o[$bits(window_t)-1:0] = cfg.early_win;
                prdata_o[WIN_LATE_LSB +: $bits(window_t)] = cfg.late_win;
            end
            STATUS:     prdata_o = status;
            LOST_CNT:   prdata_o = lost_cnt;
            default:    prdata_o = '0;
        endcase
    end

    // writes land at the end of the access phase
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cfg.enable     <= 1'b0;
            cfg.ssb_period <= PERIOD_RST;
            cfg.early_win  <= WIN_RST;
            cfg.late_win   <= WIN_RST;
        end else if (access && pwrite_i && !acc_err) begin
            case (paddr_i)
                CTRL:       cfg.enable <= pwdata_i[0];
                SSB_PERIOD: cfg.ssb_period <= pwdata_i[$bits(ssb_period_t)-1:0];
                WINDOW: begin
                    cfg.early_win <= pwdata_i[$bits(window_t)-1:0];
                    cfg.late_win  <= pwdata_i[WIN_LATE_LSB +: $bits(window_t)];
                end
                default: ;
            endcase
        end
    end

    // lost locks, saturating
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            lost_cnt <= '0;
        end else if (cfg.lost_pulse && lost_cnt != '1) begin
            lost_cnt <= lost_cnt + 1'b1;
        end
    end

    // access phase always follows a setup phase and never waits
    a_apb_access: assert property (@(posedge clk_i) disable iff (!reset_ni)
        penable_i |-> psel_i && $past(psel_i) && pready_o);

endmodule

`default_nettype wire

/* include/nr_settings.svh */
`ifndef NR_SETTINGS_SVH
`define NR_SETTINGS_SVH

// frame numerology, scaled down for simulation
`define NR_FFT_LEN      16
`define NR_CP1_LEN      4
`define NR_CP2_LEN      2
`define NR_SYM_PER_SF   14

// SSB symbol assumed until ibar is decoded
`define NR_SSB_SYM0     3

// IQ sample width
`define NR_DW           32

// APB bus
`define NR_APB_AW       8
`define NR_APB_DW       32

`endif

/* verif/nr_sync_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nr_settings.svh"

module nr_sync_checker (
    input wire logic              clk_i,
    input wire logic              reset_ni,
    input wire logic [`NR_DW-1:0] s_tdata_i,
    input wire logic              s_tvalid_i,
    input wire logic              nid2_valid_i,
    input wire logic [2:0]        ibar_i,
    input wire logic              ibar_valid_i,
    input wire logic [1:0]        pss_mode_i,
    input wire logic [`NR_DW-1:0] m_tdata_i,
    input wire logic              m_tvalid_i,
    input wire logic [4:0]        cp_len_i,
    input wire logic              symbol_start_i,
    input wire logic              pbch_start_i,
    input wire logic              sss_start_i
);
    localparam int SF = `NR_SYM_PER_SF;

    string             test_name = "none";
    int                err_cnt = 0;
    int                test_errs = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                period_sym = 28;
    int                period_smp = 0;
    int                early = 0;
    int                late = 0;
    // reference grid
    bit                active = 0;
    bit                synced = 0;
    bit                win = 0;
    bit                cp_known = 0;
    int                sc = 0;
    int                sym = 0;
    int                since = 0;
    int                len;
    int                since_ssb = 0;
    bit                live = 0;
    logic              exp_sym_start = 0;
    logic              exp_pbch = 0;
    logic              exp_sss = 0;
    int                exp_cp = 0;
    logic [`NR_DW-1:0] exp_tdata = '0;
    logic              exp_tvalid = 0;
    logic [1:0]        prev_mode = 2'd0;
    int                pbch_seen = 0;
    int                find_to_pause = 0;
    int                find_to_search = 0;

    // long prefix on symbols 0 and 7
    function automatic int cp_of(input int s);
        return (s == 0 || s == 7) ? `NR_CP1_LEN : `NR_CP2_LEN;
    endfunction

    function automatic int ibar_shift(input logic [2:0] k);
        case (k[1:0])
            2'd0: return 0;
            2'd1: return 6;
            2'd2: return 14 % SF;
            default: return 20 % SF;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s expected %0h actual %0h", test_name, what, expected, actual);
            err_cnt++;
            test_errs++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", test_name, msg);
        err_cnt++;
        test_errs++;
    endtask

    task automatic begin_test(input string name, input int period, input int early_w,
                              input int late_w);
        test_name  = name;
        period_sym = period;
        early      = early_w;
        late       = late_w;
        period_smp = 0;
        for (int j = 0; j < period; j++) begin
            period_smp += `NR_FFT_LEN + cp_of(j % SF);
        end
        test_errs      = 0;
        pbch_seen      = 0;
        find_to_pause  = 0;
        find_to_search = 0;
        active         = 0;
        cp_known       = 0;
    endtask

    task automatic end_test(input bit grid, input bit delivered);
        if (grid) begin
            check_value("pbch_count", delivered ? 2 : 1, pbch_seen);
            check_value("find_to_pause", delivered ? 1 : 0, find_to_pause);
            check_value("find_to_search", delivered ? 0 : 1, find_to_search);
        end
        tests_run++;
        if (test_errs == 0) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("%s finished with %0d errors", test_name, test_errs);
        end
    endtask

    task automatic report_counts();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_cnt);
    endtask

    // model the grid from the inputs the DUT sees at this edge
    always @(posedge clk_i) begin
        live          = reset_ni;
        exp_tdata     = s_tdata_i;
        exp_tvalid    = s_tvalid_i;
        exp_sym_start = 0;
        exp_pbch      = 0;
        exp_sss       = 0;
        if (!reset_ni) begin
            active = 0;
        end else if (!active) begin
            if (nid2_valid_i) begin
                active        = 1;
                synced        = 0;
                win           = 0;
                sc            = 1;
                sym           = `NR_SSB_SYM0;
                since         = 0;
                exp_cp        = cp_of(sym);
                cp_known      = 1;
                exp_sym_start = 1;
                exp_pbch      = 1;
            end
        end else begin
            if (ibar_valid_i && !synced) begin
                sym    = (sym + ibar_shift(ibar_i)) % SF;
                synced = 1;
            end
            if (sc == 0) begin
                exp_sym_start = 1;
                exp_cp        = cp_of(sym);
                exp_sss       = (since == 2);
            end
            if (win) begin
                if (nid2_valid_i) begin
                    exp_pbch = 1;
                    win      = 0;
                end else if (sc == 3) begin
                    active = 0;
                    win    = 0;
                end
            end
            len = `NR_FFT_LEN + cp_of(sym);
            if (synced && since == period_sym - 1 && sc == len - 2) begin
                win = 1;
            end
            if (sc == len - 1) begin
                sc    = 0;
                sym   = (sym + 1) % SF;
                since = (since == period_sym - 1) ? 0 : since + 1;
            end else begin
                sc = sc + 1;
            end
        end
        since_ssb = nid2_valid_i ? 0 : since_ssb + 1;
    end

    // outputs are settled by the falling edge
    always @(negedge clk_i) begin
        if (live) begin
            check_value("m_tdata", exp_tdata, m_tdata_i);
            check_value("m_tvalid", exp_tvalid, m_tvalid_i);
            check_value("symbol_start", exp_sym_start, symbol_start_i);
            check_value("pbch_start", exp_pbch, pbch_start_i);
            check_value("sss_start", exp_sss, sss_start_i);
            if (cp_known) begin
                check_value("cp_len", exp_cp, cp_len_i);
            end
            if (pbch_start_i) begin
                pbch_seen++;
            end
            if (pss_mode_i != prev_mode) begin
                // SEARCH 0, FIND 1, PAUSE 2
                if (prev_mode == 2'd0 && pss_mode_i == 2'd2) begin
                end else if (prev_mode == 2'd2 && pss_mode_i == 2'd1) begin
                    if (since_ssb < period_smp - early - 1 || since_ssb > period_smp - early + 1) begin
                        check_value("find_entry", period_smp - early, since_ssb);
                    end
                end else if (prev_mode == 2'd1 && pss_mode_i == 2'd2) begin
                    find_to_pause++;
                end else if (prev_mode == 2'd1 && pss_mode_i == 2'd0) begin
                    find_to_search++;
                    if (since_ssb < period_smp + late || since_ssb > period_smp + late + 2) begin
                        check_value("search_return", period_smp + late + 1, since_ssb);
                    end
                end else begin
                    report_problem("pss mode changed in an illegal order");
                end
            end
        end
        prev_mode = pss_mode_i;
    end

endmodule

`default_nettype wire

/* verif/tb_nr_sync.sv */
`timescale 1ns/1ns
`default_nettype none

`include "nr_settings.svh"

module tb_nr_sync;
    localparam logic [7:0] A_CTRL   = 8'h00;
    localparam logic [7:0] A_PERIOD = 8'h04;
    localparam logic [7:0] A_WINDOW = 8'h08;
    localparam logic [7:0] A_STATUS = 8'h0C;
    localparam logic [7:0] A_LOST   = 8'h10;
    localparam int EARLY = 10;
    localparam int LATE  = 6;
    localparam int IBAR_DELAY = 3;

    typedef struct {
        string name;
        int    period;
        int    ibar;
        bit    deliver;
        int    exp_lost;
    } scenario_t;

    logic                   clk_i;
    logic                   reset_ni;
    logic                   psel_i;
    logic                   penable_i;
    logic                   pwrite_i;
    logic [`NR_APB_AW-1:0]  paddr_i;
    logic [`NR_APB_DW-1:0]  pwdata_i;
    wire  [`NR_APB_DW-1:0]  prdata_o;
    wire                    pready_o;
    wire                    pslverr_o;
    logic [`NR_DW-1:0]      s_tdata_i;
    logic                   s_tvalid_i;
    logic [1:0]             nid2_i;
    logic                   nid2_valid_i;
    logic [2:0]             ibar_i;
    logic                   ibar_valid_i;
    wire  [1:0]             pss_mode_o;
    wire  [`NR_DW-1:0]      m_tdata_o;
    wire                    m_tvalid_o;
    wire  [4:0]             cp_len_o;
    wire                    symbol_start_o;
    wire                    pbch_start_o;
    wire                    sss_start_o;
    scenario_t              scenarios [4];

    nr_sync_top u_nr_sync_top (.*);

    nr_sync_checker u_chk (
        .clk_i(clk_i), .reset_ni(reset_ni), .s_tdata_i(s_tdata_i), .s_tvalid_i(s_tvalid_i),
        .nid2_valid_i(nid2_valid_i), .ibar_i(ibar_i), .ibar_valid_i(ibar_valid_i),
        .pss_mode_i(pss_mode_o), .m_tdata_i(m_tdata_o), .m_tvalid_i(m_tvalid_o),
        .cp_len_i(cp_len_o), .symbol_start_i(symbol_start_o), .pbch_start_i(pbch_start_o),
        .sss_start_i(sss_start_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // random samples, valid on every cycle
    initial begin
        void'($urandom(8));
        forever begin
            @(posedge clk_i);
            s_tdata_i  <= $urandom;
            s_tvalid_i <= 1'b1;
        end
    end

    initial begin
        #200000;
        $display("simulation ran past its time limit");
        $display("Test failed");
        $finish;
    end

    // samples from one SSB to the next, long CP on symbols 0 and 7
    function automatic int ssb_gap_samples(input int period, input int ibar);
        int s0;
        int s;
        int total;
        s0 = (`NR_SSB_SYM0 + ((ibar % 4 == 1 || ibar % 4 == 3) ? 6 : 0)) % `NR_SYM_PER_SF;
        total = 0;
        for (int j = 0; j < period; j++) begin
            s = (s0 + j) % `NR_SYM_PER_SF;
            total += `NR_FFT_LEN + ((s == 0 || s == 7) ? `NR_CP1_LEN : `NR_CP2_LEN);
        end
        return total;
    endfunction

    task automatic apb_access(input bit write, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waited;
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= write;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk_i);
        penable_i <= 1'b1;
        waited = 0;
        @(negedge clk_i);
        while (!pready_o && waited < 20) begin
            @(negedge clk_i);
            waited++;
        end
        if (!pready_o) begin
            u_chk.report_problem("APB slave never raised pready");
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input bit exp_err);
        logic [31:0] unused;
        logic        err;
        apb_access(1'b1, addr, data, unused, err);
        u_chk.check_value("pslverr_on_write", exp_err, err);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, input bit exp_err);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        u_chk.check_value("pslverr_on_read", exp_err, err);
    endtask

    task automatic apply_reset();
        reset_ni     <= 1'b0;
        nid2_valid_i <= 1'b0;
        ibar_valid_i <= 1'b0;
        repeat (5) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(posedge clk_i);
    endtask

    task automatic run_registers();
        logic [31:0] data;
        u_chk.begin_test("apb_registers", 28, 8, 8);
        apply_reset();
        write_reg(A_PERIOD, 32'h9A35, 1'b0);
        read_reg(A_PERIOD, data, 1'b0);
        u_chk.check_value("SSB_PERIOD", 32'h9A35, data);
        write_reg(A_WINDOW, 32'h0005_000A, 1'b0);
        read_reg(A_WINDOW, data, 1'b0);
        u_chk.check_value("WINDOW", 32'h0005_000A, data);
        write_reg(A_CTRL, 32'h1, 1'b0);
        read_reg(A_CTRL, data, 1'b0);
        u_chk.check_value("CTRL", 32'h1, data);
        read_reg(8'h14, data, 1'b1);
        write_reg(A_STATUS, 32'h3, 1'b1);
        u_chk.end_test(1'b0, 1'b0);
    endtask

    task automatic run_scenario(input scenario_t sc);
        logic [31:0] data;
        int          gap;
        int          tries;
        u_chk.begin_test(sc.name, sc.period, EARLY, LATE);
        apply_reset();
        write_reg(A_PERIOD, sc.period, 1'b0);
        write_reg(A_WINDOW, (LATE << 16) | EARLY, 1'b0);
        write_reg(A_CTRL, 32'h1, 1'b0);
        gap = ssb_gap_samples(sc.period, sc.ibar);
        ibar_i <= 3'(sc.ibar);
        @(posedge clk_i);
        nid2_i       <= 2'd1;
        nid2_valid_i <= 1'b1;
        for (int i = 1; i <= gap; i++) begin
            @(posedge clk_i);
            nid2_valid_i <= (i == gap) && sc.deliver;
            ibar_valid_i <= (i == IBAR_DELAY);
        end
        @(posedge clk_i);
        nid2_valid_i <= 1'b0;
        tries = 0;
        if (sc.deliver) begin
            // next SSS shows the grid ran past the search window
            @(negedge clk_i);
            while (!sss_start_o && tries < 200) begin
                @(negedge clk_i);
                tries++;
            end
            if (!sss_start_o) begin
                u_chk.report_problem("no SSS start after the second SSB");
            end
        end else begin
            read_reg(A_STATUS, data, 1'b0);
            while (data[1:0] != 2'd0 && tries < 40) begin
                read_reg(A_STATUS, data, 1'b0);
                tries++;
            end
            tries = 0;
            while (pss_mode_o != 2'd0 && tries < 200) begin
                @(negedge clk_i);
                tries++;
            end
            if (pss_mode_o != 2'd0) begin
                u_chk.report_problem("detector mode did not return to SEARCH");
            end
        end
        read_reg(A_STATUS, data, 1'b0);
        u_chk.check_value("STATUS.lock", sc.deliver ? 2 : 0, data[1:0]);
        read_reg(A_LOST, data, 1'b0);
        u_chk.check_value("LOST_CNT", sc.exp_lost, data);
        u_chk.end_test(1'b1, sc.deliver);
    endtask

    initial begin
        reset_ni     = 1'b0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        s_tdata_i    = '0;
        s_tvalid_i   = 1'b0;
        nid2_i       = '0;
        nid2_valid_i = 1'b0;
        ibar_i       = '0;
        ibar_valid_i = 1'b0;
        scenarios[0] = '{"ssb_p28_ibar1_kept", 28, 1, 1'b1, 0};
        scenarios[1] = '{"ssb_p14_ibar0_kept", 14, 0, 1'b1, 0};
        scenarios[2] = '{"ssb_p28_ibar2_lost", 28, 2, 1'b0, 1};
        scenarios[3] = '{"ssb_p14_ibar3_lost", 14, 3, 1'b0, 1};
        run_registers();
        foreach (scenarios[i]) begin
            run_scenario(scenarios[i]);
        end
        u_chk.report_counts();
        if (u_chk.err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
design/nr_frame_pkg.sv
design/nr_cfg_pkg.sv
design/ssb_event_if.sv
design/sync_cfg_if.sv
design/sync_regs.sv
design/pss_window_ctrl.sv
design/frame_sync.sv
design/nr_sync_top.sv
verif/nr_sync_checker.sv
verif/tb_nr_sync.sv
